//--- flist.f
+incdir+include
hdl/dcache_addr_pkg.sv
hdl/dcache_ctrl_pkg.sv
hdl/way_store.sv
hdl/tag_lookup.sv
hdl/miss_controller.sv
hdl/axi_burst_master.sv
hdl/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

//--- hdl/axi_burst_master.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module axi_burst_master
	import dcache_addr_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start_read,
	input logic start_write,
	input line_addr_t line_addr,
	input word_t wb_word,
	output logic addr_done,
	output logic beat_done,
	output offset_t beat_word,
	output logic burst_done,
	output logic [`DCACHE_ADDR_W-1:0] araddr,
	output logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rlast,
	output logic rready,
	output logic [`DCACHE_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output word_t wdata,
	output logic wvalid,
	output logic wlast,
	input logic wready,
	input logic bvalid,
	output logic bready
);

	// beat before the last one, wlast is set when it goes out
	localparam offset_t pre_last = offset_t'(`DCACHE_LINE_WORDS - 2);

	logic [`DCACHE_ADDR_W-1:0] burst_addr;
	offset_t beat_cnt;
	logic b_pending;
	logic r_xfer;
	logic w_xfer;

	assign r_xfer = rvalid && rready;
	assign w_xfer = wvalid && wready;
	assign araddr = burst_addr;
	assign awaddr = burst_addr;
	assign bready = 1'b1;
	assign addr_done = (arvalid && arready) || (awvalid && awready);
	assign beat_done = r_xfer || w_xfer;
	assign beat_word = beat_cnt;
	assign burst_done = (r_xfer && rlast) || (bvalid && b_pending);

	// bursts always start at word 0 of the line
	always_ff @(posedge clk)
	begin
		if (start_read || start_write)
			burst_addr <= {line_addr, {(`DCACHE_OFFSET_W + 2){1'b0}}};
	end

	// word stays on wdata until the slave takes it
	always_ff @(posedge clk)
	begin
		if ((awvalid && awready) || (w_xfer && !wlast))
			wdata <= wb_word;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			rready <= 1'b0;
			wvalid <= 1'b0;
			wlast <= 1'b0;
			b_pending <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			if (start_read)
				arvalid <= 1'b1;
			if (start_write)
				awvalid <= 1'b1;
			if (start_read || start_write)
				beat_cnt <= '0;
			if (arvalid && arready)
			begin
				arvalid <= 1'b0;
				rready <= 1'b1;
			end
			if (awvalid && awready)
			begin
				awvalid <= 1'b0;
				wvalid <= 1'b1;
			end
			if (r_xfer)
			begin
				beat_cnt <= beat_cnt + 1'b1;
				if (rlast)
					rready <= 1'b0;
			end
			if (w_xfer)
			begin
				beat_cnt <= beat_cnt + 1'b1;
				wlast <= (beat_cnt == pre_last);
				if (wlast)
				begin
					wvalid <= 1'b0;
					wlast <= 1'b0;
					b_pending <= 1'b1;
				end
			end
			if (bvalid && b_pending)
				b_pending <= 1'b0;
		end
	end

	// write beat is held while the slave stalls
	assert property (@(posedge clk) disable iff (!rst_n)
		(wvalid && !wready) |=> (wvalid && $stable(wdata)));

	assert property (@(posedge clk) disable iff (!rst_n)
		(arvalid && !arready) |=> (arvalid && $stable(araddr)));

endmodule

//--- hdl/dcache_addr_pkg.sv
`include "dcache_settings.svh"

package dcache_addr_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] byte_en_t;

	// address fields, high to low: tag, index, offset, byte lane
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;
	typedef logic [`DCACHE_INDEX_W-1:0] index_t;
	typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

	// line base as sent to the bus, and word slot inside a data way
	typedef logic [`DCACHE_TAG_W+`DCACHE_INDEX_W-1:0] line_addr_t;
	typedef logic [`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1:0] word_addr_t;

	// per-set bookkeeping of one way
	typedef struct packed {
		tag_t tag;
		logic valid;
		logic dirty;
	} tag_entry_t;

endpackage

//--- hdl/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

	// idle and hit both accept requests, the rest belong to a miss
	typedef enum logic [2:0] {
		st_idle,
		st_hit,
		st_wb_addr,
		st_wb_data,
		st_wb_resp,
		st_fill_addr,
		st_fill_data,
		st_done
	} ctrl_state_t;

	// 0 or 1 of the two ways
	typedef logic way_t;

endpackage

//--- hdl/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top
	import dcache_addr_pkg::*;
	import dcache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// CPU data port
	input logic cpu_re,
	input logic cpu_we,
	input logic [`DCACHE_ADDR_W-1:0] cpu_addr,
	input byte_en_t cpu_byte_en,
	input word_t cpu_wdata,
	output word_t cpu_rdata,
	output logic cpu_stall,
	// AXI read channels
	output logic [`DCACHE_ADDR_W-1:0] araddr,
	output logic arvalid,
	input logic arready,
	input word_t rdata,
	input logic rvalid,
	input logic rlast,
	output logic rready,
	// AXI write channels
	output logic [`DCACHE_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output word_t wdata,
	output logic wvalid,
	output logic wlast,
	input logic wready,
	input logic bvalid,
	output logic bready
);

	index_t index;
	offset_t offset;
	offset_t beat_word;
	tag_t tag;
	tag_t victim_tag;
	way_t hit_way;
	way_t victim_way;
	way_t touch_way;
	tag_entry_t tag0;
	tag_entry_t tag1;
	tag_entry_t tag_wdata;
	word_t data0;
	word_t data1;
	word_t data_wdata;
	word_t wb_word;
	word_addr_t data_raddr;
	word_addr_t data_waddr;
	line_addr_t line_addr;
	logic [1:0] tag_we;
	logic [1:0] data_we;
	logic hit;
	logic victim_dirty;
	logic lru_touch;
	logic start_read;
	logic start_write;
	logic addr_done;
	logic beat_done;
	logic burst_done;

	tag_lookup u_lookup (.*);
	miss_controller u_ctrl (.*);
	axi_burst_master u_bus (.*);

	// tag entries, one per set and way
	way_store #(.entry_t(tag_entry_t), .depth(`DCACHE_SETS)) u_tag0 (
		.clk(clk), .rst_n(rst_n), .raddr(index), .rdata(tag0),
		.we(tag_we[0]), .waddr(index), .wdata(tag_wdata)
	);
	way_store #(.entry_t(tag_entry_t), .depth(`DCACHE_SETS)) u_tag1 (
		.clk(clk), .rst_n(rst_n), .raddr(index), .rdata(tag1),
		.we(tag_we[1]), .waddr(index), .wdata(tag_wdata)
	);

	// line data, addressed by set and word
	way_store #(.entry_t(word_t), .depth(`DCACHE_SETS * `DCACHE_LINE_WORDS)) u_data0 (
		.clk(clk), .rst_n(rst_n), .raddr(data_raddr), .rdata(data0),
		.we(data_we[0]), .waddr(data_waddr), .wdata(data_wdata)
	);
	way_store #(.entry_t(word_t), .depth(`DCACHE_SETS * `DCACHE_LINE_WORDS)) u_data1 (
		.clk(clk), .rst_n(rst_n), .raddr(data_raddr), .rdata(data1),
		.we(data_we[1]), .waddr(data_waddr), .wdata(data_wdata)
	);

endmodule

//--- hdl/miss_controller.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module miss_controller
	import dcache_addr_pkg::*;
	import dcache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_re,
	input logic cpu_we,
	input byte_en_t cpu_byte_en,
	input word_t cpu_wdata,
	output logic cpu_stall,
	input index_t index,
	input offset_t offset,
	input tag_t tag,
	input logic hit,
	input way_t hit_way,
	input way_t victim_way,
	input tag_t victim_tag,
	input logic victim_dirty,
	input word_t data0,
	input word_t data1,
	input word_t rdata,
	output logic [1:0] tag_we,
	output tag_entry_t tag_wdata,
	output logic [1:0] data_we,
	output word_addr_t data_raddr,
	output word_addr_t data_waddr,
	output word_t data_wdata,
	output word_t wb_word,
	output logic lru_touch,
	output way_t touch_way,
	output logic start_read,
	output logic start_write,
	output line_addr_t line_addr,
	input logic addr_done,
	input logic beat_done,
	input offset_t beat_word,
	input logic burst_done
);

	localparam offset_t last_word = offset_t'(`DCACHE_LINE_WORDS - 1);

	ctrl_state_t state;
	ctrl_state_t state_next;
	way_t fill_way;
	logic req;
	logic accept;
	logic miss;
	offset_t rd_word;
	word_t hit_word;
	word_t merged;

	assign req = cpu_re || cpu_we;
	assign accept = (state == st_idle) || (state == st_hit);
	assign miss = accept && req && !hit;
	assign cpu_stall = !accept || miss;

	// dirty victim is written out first, refill follows its write response
	assign start_write = miss && victim_dirty;
	assign start_read = (miss && !victim_dirty) || (state == st_wb_resp && burst_done);
	assign line_addr = start_write ? {victim_tag, index} : {tag, index};

	// during writeback the read runs one word ahead of the beat on the bus
	always_comb
	begin
		if (accept)
			rd_word = offset;
		else if (beat_done)
			rd_word = offset_t'(beat_word + 1'b1);
		else
			rd_word = beat_word;
	end

	assign data_raddr = {index, rd_word};
	assign wb_word = fill_way ? data1 : data0;
	assign hit_word = hit_way ? data1 : data0;

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			merged[8*i +: 8] = cpu_byte_en[i] ? cpu_wdata[8*i +: 8] : hit_word[8*i +: 8];
	end

	always_comb
	begin
		tag_we = 2'b00;
		data_we = 2'b00;
		lru_touch = 1'b0;
		touch_way = hit_way;
		tag_wdata.tag = tag;
		tag_wdata.valid = 1'b1;
		tag_wdata.dirty = 1'b1;
		data_waddr = {index, offset};
		data_wdata = merged;
		if (accept && hit)
		begin
			lru_touch = 1'b1;
			if (cpu_we)
			begin
				tag_we[hit_way] = 1'b1;
				data_we[hit_way] = 1'b1;
			end
		end
		else if (state == st_fill_data && beat_done)
		begin
			data_we[fill_way] = 1'b1;
			data_waddr = {index, beat_word};
			data_wdata = rdata;
			// last beat, line becomes valid and clean
			if (burst_done)
			begin
				tag_we[fill_way] = 1'b1;
				tag_wdata.dirty = 1'b0;
				lru_touch = 1'b1;
				touch_way = fill_way;
			end
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle, st_hit:
			begin
				if (hit)
					state_next = st_hit;
				else if (miss)
					state_next = victim_dirty ? st_wb_addr : st_fill_addr;
				else
					state_next = st_idle;
			end
			st_wb_addr:
				if (addr_done)
					state_next = st_wb_data;
			st_wb_data:
				if (beat_done && beat_word == last_word)
					state_next = st_wb_resp;
			st_wb_resp:
				if (burst_done)
					state_next = st_fill_addr;
			st_fill_addr:
				if (addr_done)
					state_next = st_fill_data;
			st_fill_data:
				if (burst_done)
					state_next = st_done;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= state_next;
	end

	// lru moves on the last refill beat, so the way is kept from the miss
	always_ff @(posedge clk)
	begin
		if (miss)
			fill_way <= victim_way;
	end

	// a refill ends on the last word of the line
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_fill_data && burst_done) |-> (beat_done && beat_word == last_word));

endmodule

//--- hdl/tag_lookup.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tag_lookup
	import dcache_addr_pkg::*;
	import dcache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [`DCACHE_ADDR_W-1:0] cpu_addr,
	input logic cpu_re,
	input logic cpu_we,
	input tag_entry_t tag0,
	input tag_entry_t tag1,
	input word_t data0,
	input word_t data1,
	input logic lru_touch,
	input way_t touch_way,
	output index_t index,
	output offset_t offset,
	output tag_t tag,
	output logic hit,
	output way_t hit_way,
	output way_t victim_way,
	output tag_t victim_tag,
	output logic victim_dirty,
	output word_t cpu_rdata
);

	logic match0;
	logic match1;
	tag_entry_t victim;
	// one bit per set, points at the way to replace next
	logic [`DCACHE_SETS-1:0] lru;

	// byte lane bits are dropped below the offset
	assign offset = cpu_addr[2 +: `DCACHE_OFFSET_W];
	assign index = cpu_addr[2 + `DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
	assign tag = cpu_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

	assign match0 = tag0.valid && (tag0.tag == tag);
	assign match1 = tag1.valid && (tag1.tag == tag);
	assign hit = (cpu_re || cpu_we) && (match0 || match1);
	assign hit_way = match1;

	assign victim_way = lru[index];
	assign victim = victim_way ? tag1 : tag0;
	assign victim_tag = victim.tag;
	assign victim_dirty = victim.valid && victim.dirty;

	// touched way becomes most recent, the other one is next to go
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			lru <= '0;
		else if (lru_touch)
			lru[index] <= ~touch_way;
	end

	always_ff @(posedge clk)
	begin
		if (cpu_re && hit)
			cpu_rdata <= hit_way ? data1 : data0;
	end

	// refill only ever goes into the victim, so a tag lives in one way
	assert property (@(posedge clk) disable iff (!rst_n) !(match0 && match1));

endmodule

//--- hdl/way_store.sv
`timescale 1ns/1ps

module way_store #(
	parameter type entry_t = logic [31:0],
	parameter int depth = 4
) (
	input logic clk,
	input logic rst_n,
	input logic [$clog2(depth)-1:0] raddr,
	output entry_t rdata,
	input logic we,
	input logic [$clog2(depth)-1:0] waddr,
	input entry_t wdata
);

	entry_t mem [depth];

	// read is combinational, lookup happens in the same cycle
	assign rdata = mem[raddr];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end
		else if (we)
			mem[waddr] <= wdata;
	end

endmodule

//--- include/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address on the CPU and memory side
`define DCACHE_ADDR_W 32

// word within a line, then set select
`define DCACHE_OFFSET_W 2
`define DCACHE_INDEX_W 2

// whatever is left above index, offset and the two byte lane bits
`define DCACHE_TAG_W (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W - 2)

`define DCACHE_LINE_WORDS (1 << `DCACHE_OFFSET_W)
`define DCACHE_SETS (1 << `DCACHE_INDEX_W)

`endif

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module tb_dcache -f flist.f -o sim_dcache || exit 1
out=$(./obj_dir/sim_dcache)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache
	import dcache_addr_pkg::*;
();

	localparam int timeout_cycles = 4000;

	logic clk;
	logic rst_n;
	logic cpu_re;
	logic cpu_we;
	logic [`DCACHE_ADDR_W-1:0] cpu_addr;
	byte_en_t cpu_byte_en;
	word_t cpu_wdata;
	word_t cpu_rdata;
	logic cpu_stall;
	logic [`DCACHE_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	word_t rdata;
	logic rvalid;
	logic rlast;
	logic rready;
	logic [`DCACHE_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	word_t wdata;
	logic wvalid;
	logic wlast;
	logic wready;
	logic bvalid;
	logic bready;
	logic stall_en;
	logic [2:0] rand_bits;
	logic [31:0] lfsr_state;
	int cycle_count = 0;
	int ar_cycles = 0;
	int r_beats = 0;
	int b_resps = 0;
	int last_ar_cycle = 0;
	int last_b_cycle = 0;
	// bus activity seen by the monitor
	word_t w_data_q[$];
	logic w_last_q[$];
	logic [`DCACHE_ADDR_W-1:0] aw_addr_q[$];
	logic [`DCACHE_ADDR_W-1:0] ar_addr_q[$];

	dcache_top dut (
		.clk(clk), .rst_n(rst_n),
		.cpu_re(cpu_re), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
		.cpu_byte_en(cpu_byte_en), .cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata), .cpu_stall(cpu_stall),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wlast(wlast), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	tb_mem_model u_mem (
		.clk(clk), .rst_n(rst_n), .stall_en(stall_en), .rand_bits(rand_bits),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wlast(wlast), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic take_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	// new ready pattern every cycle, the model decides whether to use it
	initial
	begin
		lfsr_state = 32'h07ede5da;
		rand_bits = 3'b111;
		forever
		begin
			@(posedge clk);
			#1;
			for (int b = 0; b < 3; b++)
				rand_bits[b] = take_bit();
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout after %0d cycles, the cache never finished a request", cycle_count);
			$display("*** FAILED ***");
			$fatal(1, "run limit reached");
		end
	end

	// mid-cycle sampling, nothing moves between negedge and the next posedge
	always @(negedge clk)
	begin
		if (arvalid)
			ar_cycles++;
		if (arvalid && arready)
		begin
			ar_addr_q.push_back(araddr);
			last_ar_cycle = cycle_count;
		end
		if (rvalid && rready)
			r_beats++;
		if (awvalid && awready)
			aw_addr_q.push_back(awaddr);
		if (wvalid && wready)
		begin
			w_data_q.push_back(wdata);
			w_last_q.push_back(wlast);
		end
		if (bvalid && bready)
		begin
			b_resps++;
			last_b_cycle = cycle_count;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, expected);
			$display("*** FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	function automatic logic [31:0] line_word_addr(input tag_t tag, input index_t set,
			input offset_t word);
		return {tag, set, word, 2'b00};
	endfunction

	// never-written memory content
	function automatic word_t fill_word(input logic [31:0] addr);
		return addr ^ 32'h5a5a0000;
	endfunction

	function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
			input byte_en_t be);
		word_t result;
		result = old_word;
		for (int i = 0; i < 4; i++)
			if (be[i])
				result[8*i +: 8] = new_word[8*i +: 8];
		return result;
	endfunction

	// called just after a rising edge, returns just after the accepting edge
	task automatic cpu_access(input logic write, input logic [31:0] addr, input byte_en_t be,
			input word_t wd, output word_t rd, output int stalls);
		stalls = 0;
		cpu_re = !write;
		cpu_we = write;
		cpu_addr = addr;
		cpu_byte_en = be;
		cpu_wdata = wd;
		@(negedge clk);
		while (cpu_stall)
		begin
			stalls++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		rd = cpu_rdata;
		cpu_re = 1'b0;
		cpu_we = 1'b0;
	endtask

	task automatic read_and_check(input logic [31:0] addr, input word_t expected,
			output int stalls);
		word_t rd;
		cpu_access(1'b0, addr, 4'b0000, 32'h0, rd, stalls);
		check_value("cpu_rdata", rd, expected);
	endtask

	task automatic write_word(input logic [31:0] addr, input byte_en_t be, input word_t wd,
			output int stalls);
		word_t unused;
		cpu_access(1'b1, addr, be, wd, unused, stalls);
	endtask

	task automatic cold_read_test();
		logic [31:0] addr;
		int stalls;
		int ar_before;
		int ar_first;
		int r_before;
		addr = line_word_addr(tag_t'(32'h1000), index_t'(0), offset_t'(1));
		ar_first = ar_addr_q.size();
		r_before = r_beats;
		read_and_check(addr, fill_word(addr), stalls);
		check_value("cpu_stall on cold read", (stalls > 0) ? 32'd1 : 32'd0, 32'd1);
		check_value("read bursts", ar_addr_q.size() - ar_first, 1);
		check_value("araddr", ar_addr_q[ar_first],
			line_word_addr(tag_t'(32'h1000), index_t'(0), offset_t'(0)));
		check_value("read beats", r_beats - r_before, `DCACHE_LINE_WORDS);
		// other word of the same line comes from the cache
		ar_before = ar_cycles;
		addr = line_word_addr(tag_t'(32'h1000), index_t'(0), offset_t'(3));
		read_and_check(addr, fill_word(addr), stalls);
		check_value("cpu_stall on line hit", stalls, 0);
		check_value("arvalid cycles on line hit", ar_cycles - ar_before, 0);
	endtask

	task automatic write_hit_test();
		logic [31:0] addr;
		int stalls;
		addr = line_word_addr(tag_t'(32'h1000), index_t'(0), offset_t'(2));
		write_word(addr, 4'b0101, 32'hdeadbeef, stalls);
		check_value("cpu_stall on write hit", stalls, 0);
		read_and_check(addr, merge_bytes(fill_word(addr), 32'hdeadbeef, 4'b0101), stalls);
		check_value("cpu_stall on read after write", stalls, 0);
	endtask

	task automatic lru_test();
		logic [31:0] addr_a;
		logic [31:0] addr_b;
		logic [31:0] addr_c;
		int stalls;
		int ar_before;
		addr_a = line_word_addr(tag_t'(32'h2001), index_t'(1), offset_t'(2));
		addr_b = line_word_addr(tag_t'(32'h2002), index_t'(1), offset_t'(2));
		addr_c = line_word_addr(tag_t'(32'h2003), index_t'(1), offset_t'(2));
		read_and_check(addr_a, fill_word(addr_a), stalls);
		read_and_check(addr_b, fill_word(addr_b), stalls);
		// touching A leaves B as the victim
		read_and_check(addr_a, fill_word(addr_a), stalls);
		check_value("cpu_stall on A hit", stalls, 0);
		ar_before = ar_cycles;
		read_and_check(addr_c, fill_word(addr_c), stalls);
		check_value("arvalid seen for C", (ar_cycles > ar_before) ? 32'd1 : 32'd0, 32'd1);
		ar_before = ar_cycles;
		read_and_check(addr_a, fill_word(addr_a), stalls);
		check_value("arvalid cycles for A after C", ar_cycles - ar_before, 0);
		ar_before = ar_cycles;
		read_and_check(addr_b, fill_word(addr_b), stalls);
		check_value("arvalid seen for evicted B", (ar_cycles > ar_before) ? 32'd1 : 32'd0,
			32'd1);
	endtask

	task automatic writeback_test(input index_t set, input logic stalls_on);
		logic [31:0] base_d;
		logic [31:0] addr;
		word_t exp_line [`DCACHE_LINE_WORDS];
		int stalls;
		int aw_first;
		int w_first;
		int ar_first;
		int b_before;
		stall_en = stalls_on;
		base_d = line_word_addr(tag_t'(32'h3001), set, offset_t'(0));
		for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
			exp_line[i] = fill_word(base_d + 32'(4 * i));
		// first write misses and refills, the second one hits
		write_word(base_d + 32'd4, 4'b1111, 32'h1234abcd, stalls);
		exp_line[1] = merge_bytes(exp_line[1], 32'h1234abcd, 4'b1111);
		write_word(base_d + 32'd12, 4'b0011, 32'hfeed7788, stalls);
		exp_line[3] = merge_bytes(exp_line[3], 32'hfeed7788, 4'b0011);
		addr = line_word_addr(tag_t'(32'h3002), set, offset_t'(0));
		read_and_check(addr, fill_word(addr), stalls);
		aw_first = aw_addr_q.size();
		w_first = w_data_q.size();
		ar_first = ar_addr_q.size();
		b_before = b_resps;
		// third tag pushes the dirty line out
		addr = line_word_addr(tag_t'(32'h3003), set, offset_t'(2));
		read_and_check(addr, fill_word(addr), stalls);
		check_value("write bursts", aw_addr_q.size() - aw_first, 1);
		check_value("awaddr", aw_addr_q[aw_first], base_d);
		check_value("write beats", w_data_q.size() - w_first, `DCACHE_LINE_WORDS);
		for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
		begin
			check_value("wdata", w_data_q[w_first + i], exp_line[i]);
			check_value("wlast", 32'(w_last_q[w_first + i]),
				(i == `DCACHE_LINE_WORDS - 1) ? 32'd1 : 32'd0);
		end
		check_value("write responses", b_resps - b_before, 1);
		check_value("read bursts", ar_addr_q.size() - ar_first, 1);
		check_value("araddr", ar_addr_q[ar_first],
			line_word_addr(tag_t'(32'h3003), set, offset_t'(0)));
		// refill must not start before the writeback is acknowledged
		check_value("arready after bvalid", (last_ar_cycle > last_b_cycle) ? 32'd1 : 32'd0,
			32'd1);
		for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
			read_and_check(base_d + 32'(4 * i), exp_line[i], stalls);
		stall_en = 1'b0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		cpu_re = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_byte_en = '0;
		cpu_wdata = '0;
		stall_en = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		cold_read_test();
		write_hit_test();
		lru_test();
		writeback_test(index_t'(2), 1'b0);
		// same sequence on a fresh set with random ready stalls
		writeback_test(index_t'(3), 1'b1);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_mem_model
	import dcache_addr_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic stall_en,
	input logic [2:0] rand_bits,
	input logic [`DCACHE_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output word_t rdata,
	output logic rvalid,
	output logic rlast,
	input logic rready,
	input logic [`DCACHE_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input word_t wdata,
	input logic wvalid,
	input logic wlast,
	output logic wready,
	output logic bvalid,
	input logic bready
);

	// only written words are kept, everything else follows the fill pattern
	word_t mem [logic [`DCACHE_ADDR_W-1:0]];
	logic [`DCACHE_ADDR_W-1:0] r_addr;
	logic [`DCACHE_ADDR_W-1:0] w_addr;
	int r_beat;

	function automatic word_t mem_word(input logic [`DCACHE_ADDR_W-1:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 32'h5a5a0000;
	endfunction

	// ready is either always high or follows the random bits
	assign arready = !stall_en || rand_bits[0];
	assign awready = !stall_en || rand_bits[1];
	assign wready = !stall_en || rand_bits[2];

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			rvalid <= 1'b0;
			rlast <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			// read burst, r_beat is the beat loaded next
			if (arvalid && arready)
			begin
				rdata <= mem_word(araddr);
				r_addr <= araddr + 32'd4;
				r_beat <= 1;
				rvalid <= 1'b1;
				rlast <= 1'b0;
			end
			else if (rvalid && rready)
			begin
				if (rlast)
				begin
					rvalid <= 1'b0;
					rlast <= 1'b0;
				end
				else
				begin
					rdata <= mem_word(r_addr);
					r_addr <= r_addr + 32'd4;
					r_beat <= r_beat + 1;
					rlast <= (r_beat == `DCACHE_LINE_WORDS - 1);
				end
			end
			// write burst, response one cycle after the last beat
			if (awvalid && awready)
				w_addr <= awaddr;
			if (wvalid && wready)
			begin
				mem[w_addr] = wdata;
				w_addr <= w_addr + 32'd4;
				if (wlast)
					bvalid <= 1'b1;
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

endmodule
